/* hw/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define XLEN 32

// architectural integer registers
`define NUM_REGS 32

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

/* hw/rv_pkg.sv */
package rv_pkg;

  // major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b00_000_11,
    OPC_STORE  = 7'b01_000_11,
    OPC_BRANCH = 7'b11_000_11,
    OPC_JALR   = 7'b11_001_11,
    OPC_JAL    = 7'b11_011_11,
    OPC_OP_IMM = 7'b00_100_11,
    OPC_OP     = 7'b01_100_11,
    OPC_AUIPC  = 7'b00_101_11,
    OPC_LUI    = 7'b01_101_11,
    OPC_SYSTEM = 7'b11_100_11
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // what the execute unit does with the decoded word
  typedef enum logic [3:0] {
    KIND_ALU, KIND_LUI, KIND_AUIPC, KIND_JAL, KIND_JALR,
    KIND_BRANCH, KIND_LOAD, KIND_STORE, KIND_HALT, KIND_NOP
  } insn_kind_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered over the S-format slots
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, six ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_u;

endpackage

/* hw/decode_if.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

// decoded control, decoder to execute unit
interface decode_if;
  rv_pkg::insn_kind_e kind;
  rv_pkg::alu_op_e    alu_op;
  // second alu operand is the immediate
  logic               use_imm;
  // already sign extended for its format
  logic [`XLEN-1:0]   imm;
  // branch condition select
  logic [2:0]         funct3;
  logic [4:0]         rd;
  // never set for rd == x0
  logic               reg_we;

  modport producer (
    output kind, alu_op, use_imm, imm, funct3, rd, reg_we
  );

  modport consumer (
    input kind, alu_op, use_imm, imm, funct3, rd, reg_we
  );

endinterface

/* hw/insn_decoder.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module insn_decoder (
  input  rv_pkg::insn_u      insn,
  output logic [4:0]         rs1,
  output logic [4:0]         rs2,
  decode_if.producer         dec
);

  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0] f3;
  logic f7_zero, f7_alt;

  // funct3 and bit 30 pick the alu operation
  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] fn, input logic alt);
    rv_pkg::alu_op_e op;
    case (fn)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign rs1 = insn.r_fmt.rs1;
  assign rs2 = insn.r_fmt.rs2;
  assign f3  = insn.r_fmt.funct3;
  assign f7_zero = insn.r_fmt.funct7 == 7'b000_0000;
  assign f7_alt  = insn.r_fmt.funct7 == 7'b010_0000;

  // immediates of each format
  assign imm_i = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
  assign imm_s = {{20{insn.s_fmt.imm_hi[6]}}, insn.s_fmt.imm_hi, insn.s_fmt.imm_lo};
  assign imm_b = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                  insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {insn.u_fmt.imm, 12'h000};
  assign imm_j = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                  insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    dec.kind    = rv_pkg::KIND_NOP;
    dec.alu_op  = rv_pkg::ALU_ADD;
    dec.use_imm = 1'b0;
    dec.imm     = '0;
    dec.funct3  = f3;
    dec.rd      = insn.r_fmt.rd;
    dec.reg_we  = 1'b0;
    case (rv_pkg::opcode_e'(insn.r_fmt.opcode))
      rv_pkg::OPC_LUI: begin
        dec.kind   = rv_pkg::KIND_LUI;
        dec.imm    = imm_u;
        dec.reg_we = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        dec.kind   = rv_pkg::KIND_AUIPC;
        dec.imm    = imm_u;
        dec.reg_we = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        dec.kind   = rv_pkg::KIND_JAL;
        dec.imm    = imm_j;
        dec.reg_we = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        if (f3 == 3'b000) begin
          dec.kind   = rv_pkg::KIND_JALR;
          dec.imm    = imm_i;
          dec.reg_we = 1'b1;
        end
      end
      rv_pkg::OPC_BRANCH: begin
        // 010 and 011 are not branch conditions
        if (f3[2:1] != 2'b01) begin
          dec.kind = rv_pkg::KIND_BRANCH;
          dec.imm  = imm_b;
        end
      end
      rv_pkg::OPC_LOAD: begin
        if (f3 == 3'b010) begin
          dec.kind   = rv_pkg::KIND_LOAD;
          dec.imm    = imm_i;
          dec.reg_we = 1'b1;
        end
      end
      rv_pkg::OPC_STORE: begin
        if (f3 == 3'b010) begin
          dec.kind = rv_pkg::KIND_STORE;
          dec.imm  = imm_s;
        end
      end
      rv_pkg::OPC_OP_IMM: begin
        // shift immediates reuse the funct7 slot
        if ((f3 == 3'b001 && f7_zero) || (f3 == 3'b101 && (f7_zero || f7_alt)) ||
            (f3 != 3'b001 && f3 != 3'b101)) begin
          dec.kind    = rv_pkg::KIND_ALU;
          dec.alu_op  = alu_sel(f3, f3 == 3'b101 && insn.r_fmt.funct7[5]);
          dec.use_imm = 1'b1;
          dec.imm     = imm_i;
          dec.reg_we  = 1'b1;
        end
      end
      rv_pkg::OPC_OP: begin
        if (f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101))) begin
          dec.kind   = rv_pkg::KIND_ALU;
          dec.alu_op = alu_sel(f3, insn.r_fmt.funct7[5]);
          dec.reg_we = 1'b1;
        end
      end
      rv_pkg::OPC_SYSTEM: begin
        // only ecall, every other field zero
        if ({insn.i_fmt.imm, insn.i_fmt.rs1, f3, insn.i_fmt.rd} == 25'd0) begin
          dec.kind = rv_pkg::KIND_HALT;
        end
      end
      default: begin
      end
    endcase
    // x0 writes are dropped here
    if (insn.r_fmt.rd == 5'd0) begin
      dec.reg_we = 1'b0;
    end
  end

  always_comb begin
    if (dec.kind inside {rv_pkg::KIND_BRANCH, rv_pkg::KIND_STORE,
                         rv_pkg::KIND_HALT, rv_pkg::KIND_NOP}) begin
      a_no_we_without_rd: assert (!dec.reg_we);
    end
  end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data,
  input  logic             wr_en,
  input  logic [4:0]       wr_addr,
  input  logic [`XLEN-1:0] wr_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != 5'd0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 reads zero even before the first reset
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  a_x0_stays_zero: assert property (
    @(posedge clk) disable iff (rst)
    (wr_en && wr_addr == 5'd0) |=> (regs[0] == '0)
  );

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module exec_unit (
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  decode_if.consumer       dec,
  input  logic [`XLEN-1:0] load_data,
  output logic             wr_en,
  output logic [4:0]       wr_addr,
  output logic [`XLEN-1:0] wr_data,
  output logic [`XLEN-1:0] mem_addr,
  output logic [`XLEN-1:0] store_data,
  output logic             store_en,
  output logic [`XLEN-1:0] next_pc,
  output logic             halt_req
);

  logic [`XLEN-1:0] op_b, alu_res;
  logic [`XLEN-1:0] pc_plus4, pc_imm, rs1_imm;
  logic [4:0] shamt;
  logic br_taken;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  // shifts only look at the low five bits
  assign shamt = op_b[4:0];

  assign pc_plus4 = pc + `XLEN'd4;
  assign pc_imm   = pc + dec.imm;
  assign rs1_imm  = rs1_data + dec.imm;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:  alu_res = rs1_data + op_b;
      rv_pkg::ALU_SUB:  alu_res = rs1_data - op_b;
      rv_pkg::ALU_SLL:  alu_res = rs1_data << shamt;
      rv_pkg::ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, rs1_data < op_b};
      rv_pkg::ALU_XOR:  alu_res = rs1_data ^ op_b;
      rv_pkg::ALU_SRL:  alu_res = rs1_data >> shamt;
      rv_pkg::ALU_SRA:  alu_res = $signed(rs1_data) >>> shamt;
      rv_pkg::ALU_OR:   alu_res = rs1_data | op_b;
      default:          alu_res = rs1_data & op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  br_taken = rs1_data == rs2_data;
      3'b001:  br_taken = rs1_data != rs2_data;
      3'b100:  br_taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  br_taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  br_taken = rs1_data < rs2_data;
      3'b111:  br_taken = rs1_data >= rs2_data;
      default: br_taken = 1'b0;
    endcase
  end

  // writeback source
  always_comb begin
    case (dec.kind)
      rv_pkg::KIND_LUI:   wr_data = dec.imm;
      rv_pkg::KIND_AUIPC: wr_data = pc_imm;
      rv_pkg::KIND_JAL,
      rv_pkg::KIND_JALR:  wr_data = pc_plus4;
      rv_pkg::KIND_LOAD:  wr_data = load_data;
      default:            wr_data = alu_res;
    endcase
  end

  always_comb begin
    case (dec.kind)
      rv_pkg::KIND_JAL:    next_pc = pc_imm;
      rv_pkg::KIND_BRANCH: next_pc = br_taken ? pc_imm : pc_plus4;
      rv_pkg::KIND_JALR:   next_pc = {rs1_imm[`XLEN-1:1], 1'b0};
      // ecall parks the pc on itself
      rv_pkg::KIND_HALT:   next_pc = pc;
      default:             next_pc = pc_plus4;
    endcase
  end

  assign wr_en   = dec.reg_we;
  assign wr_addr = dec.rd;

  // word accesses only
  assign mem_addr   = {rs1_imm[`XLEN-1:2], 2'b00};
  assign store_data = rs2_data;
  assign store_en   = dec.kind == rv_pkg::KIND_STORE;
  assign halt_req   = dec.kind == rv_pkg::KIND_HALT;

  always_comb begin
    if (dec.kind == rv_pkg::KIND_JAL || (dec.kind == rv_pkg::KIND_BRANCH && br_taken)) begin
      a_pc_rel_target_aligned: assert (next_pc[1] == 1'b0);
    end
  end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_core (
  input  logic             clk,
  input  logic             rst,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output logic [`XLEN-1:0] dmem_addr,
  input  logic [`XLEN-1:0] dmem_load_data,
  output logic [`XLEN-1:0] dmem_store_data,
  output logic             dmem_store_en,
  output logic             halt,
  output logic             wb_we,
  output logic [4:0]       wb_rd,
  output logic [`XLEN-1:0] wb_data,
  output logic [`XLEN-1:0] wb_pc
);

  // low in fetch, high in execute
  logic in_exec;
  logic retire;
  logic [`XLEN-1:0] pc, next_pc;
  rv_pkg::insn_u ir;
  logic [4:0] rs1, rs2;
  logic [`XLEN-1:0] rs1_data, rs2_data;
  logic eu_wr_en, eu_store_en, halt_req;
  logic [4:0] eu_wr_addr;
  logic [`XLEN-1:0] eu_wr_data;

  decode_if dec_bus ();

  always_ff @(posedge clk) begin
    if (rst) begin
      in_exec <= 1'b0;
      pc      <= `RESET_PC;
      ir      <= '0;
      halt    <= 1'b0;
    end else if (!halt) begin
      in_exec <= !in_exec;
      if (!in_exec) begin
        ir <= imem_data;
      end else begin
        pc   <= next_pc;
        halt <= halt_req;
      end
    end
  end

  // side effects only in a live execute cycle
  assign retire = in_exec && !halt;

  insn_decoder insn_decoder_inst (
    .insn (ir),
    .rs1  (rs1),
    .rs2  (rs2),
    .dec  (dec_bus.producer)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wb_we),
    .wr_addr  (eu_wr_addr),
    .wr_data  (eu_wr_data)
  );

  exec_unit exec_unit_inst (
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dec        (dec_bus.consumer),
    .load_data  (dmem_load_data),
    .wr_en      (eu_wr_en),
    .wr_addr    (eu_wr_addr),
    .wr_data    (eu_wr_data),
    .mem_addr   (dmem_addr),
    .store_data (dmem_store_data),
    .store_en   (eu_store_en),
    .next_pc    (next_pc),
    .halt_req   (halt_req)
  );

  assign imem_addr     = pc;
  assign dmem_store_en = eu_store_en && retire;

  // writeback trace
  assign wb_we   = eu_wr_en && retire;
  assign wb_rd   = eu_wr_addr;
  assign wb_data = eu_wr_data;
  assign wb_pc   = pc;

  a_no_store_in_fetch: assert property (
    @(posedge clk) disable iff (rst) !in_exec |-> !dmem_store_en
  );

endmodule

/* test/tb_rv_core.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module tb_rv_core;

  localparam int IMEM_WORDS = 1024;
  localparam int DMEM_WORDS = 1024;
  localparam int RUN_TIMEOUT = 4000;
  localparam int ALU_COUNT = 200;

  typedef logic [`XLEN-1:0] word_t;

  // one retire as the reference model sees it
  typedef struct packed {
    logic       we;
    logic [4:0] rd;
    word_t      data;
    logic       st;
    word_t      st_addr;
    word_t      st_data;
    word_t      npc;
    logic       halt;
  } exp_t;

  logic clk;
  logic rst;
  word_t imem_addr, dmem_addr, dmem_store_data, wb_data, wb_pc;
  word_t imem_data = '0;
  word_t dmem_load_data = '0;
  logic dmem_store_en, halt, wb_we;
  logic [4:0] wb_rd;

  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t sh_regs [32];
  word_t sh_pc, wp;
  word_t rng_state = 32'd1;
  logic in_exec, ref_halt;
  exp_t exp_cur;
  int errors = 0;
  int checks = 0;
  int tests_failed = 0;
  int test_num = 0;

  rv_core rv_core_inst (
    .clk             (clk),
    .rst             (rst),
    .imem_addr       (imem_addr),
    .imem_data       (imem_data),
    .dmem_addr       (dmem_addr),
    .dmem_load_data  (dmem_load_data),
    .dmem_store_data (dmem_store_data),
    .dmem_store_en   (dmem_store_en),
    .halt            (halt),
    .wb_we           (wb_we),
    .wb_rd           (wb_rd),
    .wb_data         (wb_data),
    .wb_pc           (wb_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // memories answer on the falling edge
  always @(negedge clk) begin
    imem_data      <= imem[imem_addr[11:2]];
    dmem_load_data <= dmem[dmem_addr[11:2]];
  end

  // data memory refills on reset, stores commit at the execute edge
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= (word_t'(i) * 32'h9E37_79B1) ^ ~word_t'(i);
      end
    end else if (dmem_store_en) begin
      dmem[dmem_addr[11:2]] <= dmem_store_data;
    end
  end

  function word_t rand_word();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return word_t'($signed(a) < $signed(b));
      3'd3:    return word_t'(a < b);
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // expected effect of one instruction, straight from the RV32I rules
  function automatic exp_t ref_step(input rv_pkg::insn_u w, input word_t regs [32],
                                    input word_t pc, input word_t mem [DMEM_WORDS]);
    exp_t e;
    word_t a, b, ii, is, ib, iu, ij, ea;
    logic [6:0] f7;
    logic [2:0] f3;
    logic take;
    e = '0;
    e.rd = w.r_fmt.rd;
    e.npc = pc + 32'd4;
    a = regs[w.r_fmt.rs1];
    b = regs[w.r_fmt.rs2];
    f7 = w.r_fmt.funct7;
    f3 = w.r_fmt.funct3;
    ii = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
    is = {{20{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
    ib = {{20{w.b_fmt.imm_12}}, w.b_fmt.imm_11, w.b_fmt.imm_10_5, w.b_fmt.imm_4_1, 1'b0};
    iu = {w.u_fmt.imm, 12'h000};
    ij = {{12{w.j_fmt.imm_20}}, w.j_fmt.imm_19_12, w.j_fmt.imm_11, w.j_fmt.imm_10_1, 1'b0};
    case (w.r_fmt.opcode)
      rv_pkg::OPC_LUI: begin
        e.we = 1'b1;
        e.data = iu;
      end
      rv_pkg::OPC_AUIPC: begin
        e.we = 1'b1;
        e.data = pc + iu;
      end
      rv_pkg::OPC_JAL: begin
        e.we = 1'b1;
        e.data = pc + 32'd4;
        e.npc = pc + ij;
      end
      rv_pkg::OPC_JALR: if (f3 == 3'd0) begin
        e.we = 1'b1;
        e.data = pc + 32'd4;
        e.npc = (a + ii) & ~32'd1;
      end
      rv_pkg::OPC_BRANCH: if (f3[2:1] != 2'b01) begin
        case (f3)
          3'd0:    take = a == b;
          3'd1:    take = a != b;
          3'd4:    take = $signed(a) < $signed(b);
          3'd5:    take = $signed(a) >= $signed(b);
          3'd6:    take = a < b;
          default: take = a >= b;
        endcase
        if (take) e.npc = pc + ib;
      end
      rv_pkg::OPC_LOAD: if (f3 == 3'd2) begin
        ea = a + ii;
        e.we = 1'b1;
        e.data = mem[ea[11:2]];
      end
      rv_pkg::OPC_STORE: if (f3 == 3'd2) begin
        ea = a + is;
        e.st = 1'b1;
        e.st_addr = {ea[31:2], 2'b00};
        e.st_data = b;
      end
      rv_pkg::OPC_OP_IMM: begin
        if ((f3 == 3'd1 && f7 == 7'h00) || (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20)) ||
            (f3 != 3'd1 && f3 != 3'd5)) begin
          e.we = 1'b1;
          e.data = alu_ref(f3, f3 == 3'd5 && f7[5], a, ii);
        end
      end
      rv_pkg::OPC_OP: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          e.we = 1'b1;
          e.data = alu_ref(f3, f7[5], a, b);
        end
      end
      rv_pkg::OPC_SYSTEM: if (w[31:7] == 25'd0) begin
        e.halt = 1'b1;
        e.npc = pc;
      end
      default: begin
      end
    endcase
    if (e.rd == 5'd0) e.we = 1'b0;
    return e;
  endfunction

  task automatic check_bit(input string name, input logic expv, input logic got);
    checks++;
    if (got !== expv) begin
      errors++;
      $display("error: %s expected 0x%0h got 0x%0h", name, expv, got);
    end
  endtask

  task automatic check_addr(input string name, input word_t expv, input word_t got);
    checks++;
    if (got !== expv) begin
      errors++;
      $display("error: %s expected 0x%08h got 0x%08h", name, expv, got);
    end
  endtask

  task automatic check_wb(input logic exp_we, input logic [4:0] exp_rd, input word_t exp_data);
    check_bit("wb_we", exp_we, wb_we);
    if (exp_we && wb_we === 1'b1) begin
      checks++;
      if (wb_rd !== exp_rd || wb_data !== exp_data) begin
        errors++;
        $display("error: wb_rd/wb_data expected 0x%02h/0x%08h got 0x%02h/0x%08h",
                 exp_rd, exp_data, wb_rd, wb_data);
      end
    end
  endtask

  // shadow machine follows the core and compares every retire
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) sh_regs[i] = '0;
      sh_pc = `RESET_PC;
      in_exec = 1'b0;
      ref_halt = 1'b0;
    end else if (!ref_halt) begin
      if (!in_exec) begin
        check_addr("imem_addr", sh_pc, imem_addr);
        check_bit("wb_we", 1'b0, wb_we);
        check_bit("dmem_store_en", 1'b0, dmem_store_en);
      end else begin
        exp_cur = ref_step(imem[sh_pc[11:2]], sh_regs, sh_pc, dmem);
        check_addr("wb_pc", sh_pc, wb_pc);
        check_wb(exp_cur.we, exp_cur.rd, exp_cur.data);
        check_bit("dmem_store_en", exp_cur.st, dmem_store_en);
        if (exp_cur.st) begin
          check_addr("dmem_addr", exp_cur.st_addr, dmem_addr);
          check_addr("dmem_store_data", exp_cur.st_data, dmem_store_data);
        end
        if (exp_cur.we) sh_regs[exp_cur.rd] = exp_cur.data;
        sh_pc = exp_cur.npc;
        ref_halt = exp_cur.halt;
      end
      in_exec = !in_exec;
    end
  end

  task automatic emit(input word_t w);
    imem[wp[11:2]] = w;
    wp = wp + 32'd4;
  endtask

  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input rv_pkg::opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                  input rv_pkg::opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
  endfunction

  task automatic new_program();
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = 32'h0000_0073;
    wp = `RESET_PC;
  endtask

  task automatic run_program(input string name, input bit hold_check);
    int e0;
    int n;
    word_t pc_hold;
    e0 = errors;
    n = 0;
    test_num++;
    @(negedge clk);
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    check_addr("imem_addr", `RESET_PC, imem_addr);
    check_bit("halt", 1'b0, halt);
    check_bit("wb_we", 1'b0, wb_we);
    check_bit("dmem_store_en", 1'b0, dmem_store_en);
    while (halt !== 1'b1 && n < RUN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (halt !== 1'b1) begin
      errors++;
      $display("timeout: core did not halt within %0d cycles in %s", RUN_TIMEOUT, name);
    end else begin
      if (!ref_halt) begin
        errors++;
        $display("core halted while the reference model was still running");
      end
      if (hold_check) begin
        // the reference stopped on the ecall address
        pc_hold = sh_pc;
        repeat (10) begin
          @(negedge clk);
          check_addr("imem_addr", pc_hold, imem_addr);
          check_bit("halt", 1'b1, halt);
          check_bit("wb_we", 1'b0, wb_we);
          check_bit("dmem_store_en", 1'b0, dmem_store_en);
        end
      end
    end
    if (errors != e0) tests_failed++;
    $display("test %0d %s: %s (%0d errors)", test_num, name,
             (errors == e0) ? "ok" : "failed", errors - e0);
  endtask

  initial begin
    word_t r, r2, t, base, addr;
    logic [11:0] imm, ji, off;
    logic [20:0] jo;
    logic [6:0] f7;
    logic [2:0] f3;
    rst = 1'b1;

    new_program();
    emit(enc_i(12'd7, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
    run_program("reset state", 1'b0);

    // seed every register, then random alu traffic
    new_program();
    for (int i = 1; i < 32; i++) begin
      r = rand_word();
      emit(enc_u(r[31:12], 5'(i), rv_pkg::OPC_LUI));
      emit(enc_i(r[11:0], 5'(i), 3'd0, 5'(i), rv_pkg::OPC_OP_IMM));
    end
    repeat (ALU_COUNT) begin
      r = rand_word();
      f3 = r[2:0];
      imm = r[29:18];
      if (r[30]) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[31]) ? 7'h20 : 7'h00;
        emit({f7, r[17:13], r[12:8], f3, r[7:3], rv_pkg::OPC_OP});
      end else begin
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = r[31] ? 7'h20 : 7'h00;
        emit(enc_i(imm, r[12:8], f3, r[7:3], rv_pkg::OPC_OP_IMM));
      end
    end
    run_program("alu ops", 1'b0);

    new_program();
    repeat (12) begin
      r = rand_word();
      emit(enc_u(r[31:12], r[4:0], rv_pkg::OPC_LUI));
      emit(enc_u(r[27:8], r[9:5], rv_pkg::OPC_AUIPC));
      // forward jal over a few unused words
      jo = 21'd4 + {16'd0, r[2:0], 2'b00};
      emit(enc_j(jo, r[14:10]));
      wp = wp - 32'd4 + {11'd0, jo};
      t = wp + 32'd8 + {27'd0, r[17:15], 2'b00};
      ji = {{7{r[22]}}, r[22:18]};
      base = t - {{20{ji[11]}}, ji};
      emit(enc_i(base[11:0], 5'd0, 3'd0, 5'd5, rv_pkg::OPC_OP_IMM));
      emit(enc_i(ji, 5'd5, 3'd0, r[27:23], rv_pkg::OPC_JALR));
      wp = t;
    end
    run_program("upper and jumps", 1'b0);

    new_program();
    repeat (30) begin
      r = rand_word();
      imm = r[11:0];
      case (r[13:12])
        2'd0:    off = imm;
        2'd1:    off = imm + 12'd1 + {8'd0, r[19:16]};
        2'd2:    off = imm - 12'd1 - {8'd0, r[19:16]};
        default: off = ~imm;
      endcase
      f3 = r[22:20];
      if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd4;
      emit(enc_i(imm, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
      emit(enc_i(off, 5'd0, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));
      emit(enc_b(13'd8, 5'd2, 5'd1, f3));
      emit(enc_i(12'd1, 5'd3, 3'd0, 5'd3, rv_pkg::OPC_OP_IMM));
    end
    run_program("branches", 1'b0);

    new_program();
    repeat (20) begin
      r = rand_word();
      r2 = rand_word();
      addr = 32'd64 + {22'd0, r[9:2], 2'b00};
      off = {{7{r[16]}}, r[16:14], 2'b00};
      base = addr - {{20{off[11]}}, off};
      emit(enc_u(r2[31:12], 5'd7, rv_pkg::OPC_LUI));
      emit(enc_i(r2[11:0], 5'd7, 3'd0, 5'd7, rv_pkg::OPC_OP_IMM));
      emit(enc_i(base[11:0], 5'd0, 3'd0, 5'd6, rv_pkg::OPC_OP_IMM));
      emit(enc_s(off, 5'd7, 5'd6));
      emit(enc_i(off, 5'd6, 3'd2, 5'd8, rv_pkg::OPC_LOAD));
      // custom-0 opcode, not part of the core
      emit({r[31:12], 5'd9, 7'b000_1011});
    end
    run_program("store and load", 1'b0);

    new_program();
    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
    run_program("ecall halt", 1'b1);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_num, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hw
hw/rv_pkg.sv
hw/decode_if.sv
hw/insn_decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/rv_core.sv
test/tb_rv_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_core
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
